//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = formatCtsTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard design/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/ctsByteMux.sv
module ctsByteMux (
  input  ctsFormatPkg::ctsStateT ctsState,
  input  ctsFormatPkg::byteIdxT  byteIdx,
  // Frame contents from the MAC controller and CSR
  input  ctsFormatPkg::macAddrT  destAddr,
  input  ctsFormatPkg::durationT duration,
  input  logic                   pwrMgt,
  input  logic                   fcsBusy,
  // Byte stream toward the FCS engine
  output ctsFormatPkg::ctsByteT  ctsFcsDIn,
  output logic                   ctsFcsDInValid
);

  import ctsFormatPkg::*;

  ctsByteT frmCtrl1;
  ctsByteT frmCtrl2;
  logic    dataState;

  // Subtype, type and protocol version
  assign frmCtrl1 = {CTS_SUBTYPE, CTRL_FRAME_TYPE, PROTOCOL_VERSION};

  // Flags byte, only power management can be set in a CTS
  always_comb
  begin
    frmCtrl2              = '0;
    frmCtrl2[PWR_MGT_BIT] = pwrMgt;
  end

  ////////////////////////////////////////////////////////////
  // Byte select
  ////////////////////////////////////////////////////////////

  // Fields go out least significant byte first
  // The value holds while the engine is busy since state and index hold too
  always_comb
  begin
    ctsFcsDIn = '0;
    case (ctsState)
      ctsFrmCtrl1:
        ctsFcsDIn = frmCtrl1;
      ctsFrmCtrl2:
        ctsFcsDIn = frmCtrl2;
      ctsDurationId:
        ctsFcsDIn = duration[{byteIdx[0], 3'b000} +: 8];
      ctsRa:
        // Indexes 6 and 7 never occur in this field
        if (byteIdx < byteIdxT'(RA_BYTES))
          ctsFcsDIn = destAddr[{byteIdx, 3'b000} +: 8];
      default:
        ctsFcsDIn = '0;
    endcase
  end

  // States carrying frame bytes
  assign dataState = (ctsState == ctsFrmCtrl1) || (ctsState == ctsFrmCtrl2) ||
                     (ctsState == ctsDurationId) || (ctsState == ctsRa);

  // Valid only when the engine can take the byte
  assign ctsFcsDInValid = dataState && !fcsBusy;

endmodule

//--- design/ctsFieldCounter.sv
module ctsFieldCounter (
  input  logic                   macCoreTxClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   macCoreTxClkSoftRst_n,
  input  ctsFormatPkg::ctsStateT ctsState,
  input  logic                   fcsBusy,
  output ctsFormatPkg::byteIdxT  byteIdx,
  output logic                   fieldDoneP
);

  import ctsFormatPkg::*;

  byteIdxT lastIdx;
  logic    countEn;
  logic    byteAccept;

  // Last index of the current field, zero outside multi-byte fields
  always_comb
  begin
    case (ctsState)
      ctsDurationId: lastIdx = byteIdxT'(DURATION_BYTES - 1);
      ctsRa:         lastIdx = byteIdxT'(RA_BYTES - 1);
      default:       lastIdx = '0;
    endcase
  end

  // Counting only in the duration and address fields
  assign countEn    = (ctsState == ctsDurationId) || (ctsState == ctsRa);
  // A byte moves to the engine when it is not busy
  assign byteAccept = countEn && !fcsBusy;
  assign fieldDoneP = byteAccept && (byteIdx == lastIdx);

  ////////////////////////////////////////////////////////////
  // Byte index
  ////////////////////////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      byteIdx <= '0;
    else if (!macCoreTxClkSoftRst_n)
      byteIdx <= '0;
    else if (byteAccept)
    begin
      // Back to zero for the next field
      if (byteIdx == lastIdx)
        byteIdx <= '0;
      else
        byteIdx <= byteIdx + 3'd1;
    end
  end

endmodule

//--- design/ctsFormatPkg.sv
package ctsFormatPkg;

  ////////////////////////////////////////////////////////////
  // Width types
  ////////////////////////////////////////////////////////////

  // One frame byte toward the FCS engine
  typedef logic [7:0]  ctsByteT;

  // Receiver address of the CTS frame
  typedef logic [47:0] macAddrT;

  // Duration/ID field value
  typedef logic [15:0] durationT;

  // Byte position inside a multi-byte field
  typedef logic [2:0]  byteIdxT;

  ////////////////////////////////////////////////////////////
  // Formatter states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ctsIdle,
    ctsWait,
    ctsStartTx,
    ctsFrmCtrl1,
    ctsFrmCtrl2,
    ctsDurationId,
    ctsRa,
    ctsFcs
  } ctsStateT;

  ////////////////////////////////////////////////////////////
  // Frame constants
  ////////////////////////////////////////////////////////////

  // Frame control fields, first byte packs to 0xC4
  localparam logic [1:0] PROTOCOL_VERSION = 2'd0;
  localparam logic [1:0] CTRL_FRAME_TYPE  = 2'd1;
  localparam logic [3:0] CTS_SUBTYPE      = 4'd12;

  // Power management flag in the second frame control byte
  localparam int PWR_MGT_BIT = 4;

  // Field lengths in bytes
  localparam int DURATION_BYTES = 2;
  localparam int RA_BYTES       = 6;

endpackage

//--- design/ctsTxSequencer.sv
module ctsTxSequencer (
  input  logic                  macCoreTxClk,
  input  logic                  macCoreClkHardRst_n,
  input  logic                  macCoreTxClkSoftRst_n,
  // Trigger and timing mode from the TX controller
  input  logic                  sendCtsP,
  input  logic                  sendOnPifs,
  input  logic                  sendOnSifs,
  // Inter-frame ticks from the timers
  input  logic                  tickPifs,
  input  logic                  tickSifs,
  input  logic                  tickSlotP,
  // FCS engine handshake
  input  logic                  fcsBusy,
  input  logic                  fcsEndP,
  // Last byte of a multi-byte field accepted
  input  logic                  fieldDoneP,
  output ctsFormatPkg::ctsStateT ctsState,
  output logic                  ctsTxStartP,
  output logic                  ctsFcsStartP,
  output logic                  ctsFcsShiftTx,
  output logic                  ctsFcsEnable,
  output logic                  ctsDoneP
);

  import ctsFormatPkg::*;

  ctsStateT nextState;
  logic     txTick;

  // Tick of the selected timing mode
  // PIFS wins over SIFS, SIFS wins over slot
  assign txTick = sendOnPifs ? tickPifs  :
                  sendOnSifs ? tickSifs  :
                               tickSlotP;

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      ctsState <= ctsIdle;
    else if (!macCoreTxClkSoftRst_n)
      ctsState <= ctsIdle;
    else
      ctsState <= nextState;
  end

  // Next state
  always_comb
  begin
    nextState = ctsState;
    case (ctsState)
      // Armed only from idle
      ctsIdle:
        if (sendCtsP)
          nextState = ctsWait;
      // Hold until the selected inter-frame tick
      ctsWait:
        if (txTick)
          nextState = ctsStartTx;
      // Single cycle to start the FCS engine
      ctsStartTx:
        nextState = ctsFrmCtrl1;
      // Single-byte fields leave on an accepted byte
      ctsFrmCtrl1:
        if (!fcsBusy)
          nextState = ctsFrmCtrl2;
      ctsFrmCtrl2:
        if (!fcsBusy)
          nextState = ctsDurationId;
      // Multi-byte fields leave on the counter's done pulse
      ctsDurationId:
        if (fieldDoneP)
          nextState = ctsRa;
      ctsRa:
        if (fieldDoneP)
          nextState = ctsFcs;
      // Checksum shifted out by the engine
      ctsFcs:
        if (fcsEndP)
          nextState = ctsIdle;
      default:
        nextState = ctsIdle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////

  // PHY start in the tick cycle itself
  assign ctsTxStartP   = (ctsState == ctsWait) && (nextState == ctsStartTx);
  // FCS start one cycle after the PHY start
  assign ctsFcsStartP  = (ctsState == ctsStartTx);
  // Checksum shift from the last address byte up to the end pulse
  assign ctsFcsShiftTx = (nextState == ctsFcs) && !fcsEndP;
  // Engine enabled for the whole frame
  assign ctsFcsEnable  = (ctsState != ctsIdle);

  // Done pulse registered one cycle after the end of the checksum
  always_ff @(posedge macCoreTxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      ctsDoneP <= 1'b0;
    else if (!macCoreTxClkSoftRst_n)
      ctsDoneP <= 1'b0;
    else
      ctsDoneP <= (ctsState == ctsFcs) && fcsEndP;
  end

endmodule

//--- design/formatCts.sv
module formatCts (
  input  logic                   macCoreTxClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   macCoreTxClkSoftRst_n,
  // Frame contents
  input  ctsFormatPkg::macAddrT  destAddr,
  input  ctsFormatPkg::durationT duration,
  input  logic                   pwrMgt,
  // TX controller
  input  logic                   sendCtsP,
  input  logic                   sendOnPifs,
  input  logic                   sendOnSifs,
  output logic                   ctsDoneP,
  output logic                   ctsTxStartP,
  // Timers
  input  logic                   tickPifs,
  input  logic                   tickSifs,
  input  logic                   tickSlotP,
  // FCS engine
  input  logic                   fcsBusy,
  input  logic                   fcsEndP,
  output logic                   ctsFcsEnable,
  output logic                   ctsFcsStartP,
  output logic                   ctsFcsShiftTx,
  output ctsFormatPkg::ctsByteT  ctsFcsDIn,
  output logic                   ctsFcsDInValid
);

  import ctsFormatPkg::*;

  // Sequencer state shared with the counter and the mux
  ctsStateT ctsState;
  // Byte position and field end from the counter
  byteIdxT  byteIdx;
  logic     fieldDoneP;

  ////////////////////////////////////////////////////////////
  // Frame phase control
  ////////////////////////////////////////////////////////////

  ctsTxSequencer uSequencer (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .sendCtsP              (sendCtsP),
    .sendOnPifs            (sendOnPifs),
    .sendOnSifs            (sendOnSifs),
    .tickPifs              (tickPifs),
    .tickSifs              (tickSifs),
    .tickSlotP             (tickSlotP),
    .fcsBusy               (fcsBusy),
    .fcsEndP               (fcsEndP),
    .fieldDoneP            (fieldDoneP),
    .ctsState              (ctsState),
    .ctsTxStartP           (ctsTxStartP),
    .ctsFcsStartP          (ctsFcsStartP),
    .ctsFcsShiftTx         (ctsFcsShiftTx),
    .ctsFcsEnable          (ctsFcsEnable),
    .ctsDoneP              (ctsDoneP)
  );

  // Byte walk through duration and address
  ctsFieldCounter uFieldCounter (
    .macCoreTxClk          (macCoreTxClk),
    .macCoreClkHardRst_n   (macCoreClkHardRst_n),
    .macCoreTxClkSoftRst_n (macCoreTxClkSoftRst_n),
    .ctsState              (ctsState),
    .fcsBusy               (fcsBusy),
    .byteIdx               (byteIdx),
    .fieldDoneP            (fieldDoneP)
  );

  // Outgoing byte and valid
  ctsByteMux uByteMux (
    .ctsState       (ctsState),
    .byteIdx        (byteIdx),
    .destAddr       (destAddr),
    .duration       (duration),
    .pwrMgt         (pwrMgt),
    .fcsBusy        (fcsBusy),
    .ctsFcsDIn      (ctsFcsDIn),
    .ctsFcsDInValid (ctsFcsDInValid)
  );

endmodule

//--- test/formatCtsTb.sv
module formatCtsTb;

  import ctsFormatPkg::*;

  // Expected formatter phase, tracked alongside the DUT
  typedef enum {modelIdle, modelWait, modelStart, modelBytes, modelFcs} modelPhaseT;

  // DUT inputs
  logic     macCoreTxClk;
  logic     macCoreClkHardRst_n;
  logic     macCoreTxClkSoftRst_n;
  macAddrT  destAddr;
  durationT duration;
  logic     pwrMgt;
  logic     sendCtsP;
  logic     sendOnPifs;
  logic     sendOnSifs;
  logic     tickPifs;
  logic     tickSifs;
  logic     tickSlotP;
  logic     fcsBusy;
  logic     fcsEndP;
  // DUT outputs
  logic     ctsDoneP;
  logic     ctsTxStartP;
  logic     ctsFcsEnable;
  logic     ctsFcsStartP;
  logic     ctsFcsShiftTx;
  ctsByteT  ctsFcsDIn;
  logic     ctsFcsDInValid;

  // Trace contents, one entry per frame, ten bytes per frame in byteQ
  macAddrT    addrQ[$];
  durationT   durQ[$];
  logic       pwrQ[$];
  logic [1:0] modeQ[$];
  logic       abortQ[$];
  ctsByteT    byteQ[$];
  logic       traceLoaded = 1'b0;
  int         frameBase = 0;
  // High in the cycle that carries the tick of the frame's timing mode
  logic       tickFired = 1'b0;

  // Reference model state
  modelPhaseT phase = modelIdle;
  int         byteCount = 0;
  logic       doneDue = 1'b0;
  logic       prevBusy = 1'b0;
  ctsByteT    prevDIn = '0;
  logic       prevShift = 1'b0;
  logic       shiftRise = 1'b0;
  logic       afterAbort = 1'b0;
  int         doneCount = 0;
  int         endWait = 0;
  int         errorCount = 0;
  int         byteTotal = 0;
  int         frameTotal = 0;

  formatCts uut (.*);

  initial
  begin
    macCoreTxClk = 1'b0;
    forever #10 macCoreTxClk = ~macCoreTxClk;
  end

  task automatic flagError(input string msg);
    errorCount++;
    $display("** Error at %0t: %s", $time, msg);
  endtask

  // One in four chance of a stray tick
  function automatic logic randomPulse();
    return ($urandom_range(3, 0) == 0);
  endfunction

  ////////////////////////////////////////////////////////////
  // Trace reader
  ////////////////////////////////////////////////////////////

  task automatic loadTrace(output string problem);
    int         fd;
    int         fields;
    int         i;
    string      line;
    macAddrT    addr;
    durationT   dur;
    logic       pm;
    logic [1:0] mode;
    logic       abortFlag;
    ctsByteT    b [10];
    problem = "";
    fd = $fopen("test/formatCtsTrace.txt", "r");
    if (fd == 0)
      problem = "cannot open test/formatCtsTrace.txt";
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        // Header and blank lines carry no frame
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           addr, dur, pm, mode, abortFlag, b[0], b[1], b[2], b[3],
                           b[4], b[5], b[6], b[7], b[8], b[9]);
          if (fields != 15)
            problem = {"malformed trace line ", line};
          addrQ.push_back(addr);
          durQ.push_back(dur);
          pwrQ.push_back(pm);
          modeQ.push_back(mode);
          abortQ.push_back(abortFlag);
          for (i = 0; i < 10; i++)
            byteQ.push_back(b[i]);
        end
      end
      $fclose(fd);
      if (addrQ.size() == 0)
        problem = "the trace holds no frames";
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Selected tick follows fire, the other kinds are random strays
  task automatic driveTicks(input logic [1:0] mode, input logic fire);
    if (mode[1])
    begin
      tickPifs  <= fire;
      tickSifs  <= randomPulse();
      tickSlotP <= randomPulse();
    end
    else if (mode[0])
    begin
      tickPifs  <= randomPulse();
      tickSifs  <= fire;
      tickSlotP <= randomPulse();
    end
    else
    begin
      tickPifs  <= randomPulse();
      tickSifs  <= randomPulse();
      tickSlotP <= fire;
    end
  endtask

  task automatic runFrame(input int n);
    int strays;
    int abortAt;
    int doneBefore;
    @(posedge macCoreTxClk);
    destAddr   <= addrQ[n];
    duration   <= durQ[n];
    pwrMgt     <= pwrQ[n];
    sendOnPifs <= modeQ[n][1];
    sendOnSifs <= modeQ[n][0];
    sendCtsP   <= 1'b1;
    frameBase  = n * 10;
    doneBefore = doneCount;
    @(posedge macCoreTxClk);
    sendCtsP <= 1'b0;
    // Waiting with strays only, then the selected tick
    strays = $urandom_range(5, 0);
    repeat (strays)
    begin
      driveTicks(modeQ[n], 1'b0);
      @(posedge macCoreTxClk);
    end
    driveTicks(modeQ[n], 1'b1);
    tickFired <= 1'b1;
    @(posedge macCoreTxClk);
    tickPifs  <= 1'b0;
    tickSifs  <= 1'b0;
    tickSlotP <= 1'b0;
    tickFired <= 1'b0;
    if (abortQ[n])
    begin
      // Cut the frame somewhere inside the byte stream
      abortAt = $urandom_range(8, 1);
      while (byteCount < abortAt)
        @(posedge macCoreTxClk);
      macCoreTxClkSoftRst_n <= 1'b0;
      @(posedge macCoreTxClk);
      macCoreTxClkSoftRst_n <= 1'b1;
      repeat (2) @(posedge macCoreTxClk);
    end
    else
    begin
      while (doneCount == doneBefore)
        @(posedge macCoreTxClk);
      frameTotal++;
    end
  endtask

  // FCS engine back-pressure, about one cycle in three
  initial
  begin
    fcsBusy <= 1'b0;
    forever
    begin
      @(posedge macCoreTxClk);
      fcsBusy <= ($urandom_range(2, 0) == 0);
    end
  end

  // FCS engine end pulse 1 to 4 cycles after the shift request rises
  initial
  begin
    fcsEndP <= 1'b0;
    forever
    begin
      @(posedge macCoreTxClk);
      if (endWait == 0 && shiftRise)
        endWait = $urandom_range(4, 1);
      fcsEndP <= (endWait == 1);
      if (endWait > 0)
        endWait = endWait - 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks, sampled at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic checkCycle();
    logic       expStart;
    logic       expShift;
    logic       expValid;
    modelPhaseT nextPhase;
    ctsByteT    expByte;
    nextPhase = phase;
    expStart  = 1'b0;
    expShift  = 1'b0;
    expValid  = 1'b0;
    case (phase)
      modelIdle:
        if (sendCtsP)
          nextPhase = modelWait;
      // Start only in the cycle that carries the fired tick
      modelWait:
        if (tickFired)
        begin
          expStart  = 1'b1;
          nextPhase = modelStart;
        end
      modelStart:
        nextPhase = modelBytes;
      modelBytes:
      begin
        // The offered byte is always the next one of the frame
        expByte  = byteQ[frameBase + byteCount];
        expValid = !fcsBusy;
        if (ctsFcsDIn !== expByte)
          flagError($sformatf("frame byte %0d is %h, expected %h",
                              byteCount, ctsFcsDIn, expByte));
        if (prevBusy && ctsFcsDIn !== prevDIn)
          flagError($sformatf("ctsFcsDIn moved from %h to %h under fcsBusy",
                              prevDIn, ctsFcsDIn));
        if (expValid)
        begin
          byteCount++;
          byteTotal++;
          if (byteCount == 10)
          begin
            expShift  = 1'b1;
            nextPhase = modelFcs;
          end
        end
      end
      modelFcs:
      begin
        expShift = !fcsEndP;
        if (fcsEndP)
          nextPhase = modelIdle;
      end
      default:
        nextPhase = modelIdle;
    endcase

    if (ctsTxStartP !== expStart)
      flagError($sformatf("ctsTxStartP is %b, expected %b", ctsTxStartP, expStart));
    if (ctsFcsStartP !== (phase == modelStart))
      flagError($sformatf("ctsFcsStartP is %b in phase %s", ctsFcsStartP, phase.name()));
    if (ctsFcsEnable !== (phase != modelIdle))
      flagError($sformatf("ctsFcsEnable is %b in phase %s", ctsFcsEnable, phase.name()));
    if (ctsFcsShiftTx !== expShift)
      flagError($sformatf("ctsFcsShiftTx is %b, expected %b", ctsFcsShiftTx, expShift));
    if (ctsDoneP !== doneDue)
      flagError($sformatf("ctsDoneP is %b, expected %b", ctsDoneP, doneDue));
    if (ctsFcsDInValid !== expValid)
      flagError($sformatf("ctsFcsDInValid is %b, expected %b (fcsBusy %b)",
                          ctsFcsDInValid, expValid, fcsBusy));
    // Nothing may stay active one cycle after a soft reset
    if (afterAbort && (ctsTxStartP || ctsFcsStartP || ctsFcsShiftTx || ctsFcsEnable ||
                       ctsDoneP || ctsFcsDInValid))
      flagError("control output high in the cycle after a soft reset");

    // Model update for the next cycle
    if (ctsDoneP === 1'b1)
      doneCount++;
    doneDue  = (phase == modelFcs) && fcsEndP;
    prevBusy = (phase == modelBytes) && fcsBusy;
    prevDIn  = ctsFcsDIn;
    if (nextPhase == modelWait)
      byteCount = 0;
    afterAbort = macCoreClkHardRst_n && !macCoreTxClkSoftRst_n;
    if (!macCoreClkHardRst_n || !macCoreTxClkSoftRst_n)
    begin
      nextPhase = modelIdle;
      doneDue   = 1'b0;
    end
    phase     = nextPhase;
    shiftRise = ctsFcsShiftTx && !prevShift;
    prevShift = ctsFcsShiftTx;
  endtask

  always @(negedge macCoreTxClk)
    checkCycle();

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    string problem;
    int    n;
    macCoreClkHardRst_n   <= 1'b0;
    macCoreTxClkSoftRst_n <= 1'b1;
    destAddr              <= '0;
    duration              <= '0;
    pwrMgt                <= 1'b0;
    sendCtsP              <= 1'b0;
    sendOnPifs            <= 1'b0;
    sendOnSifs            <= 1'b0;
    tickPifs              <= 1'b0;
    tickSifs              <= 1'b0;
    tickSlotP             <= 1'b0;
    void'($urandom(32'hfbc3));
    loadTrace(problem);
    if (problem != "")
    begin
      $display("Trace error: %s", problem);
      $display("STATUS: FAIL");
      $finish;
    end
    else
    begin
      traceLoaded = 1'b1;
      repeat (8) @(posedge macCoreTxClk);
      macCoreClkHardRst_n <= 1'b1;
      for (n = 0; n < addrQ.size(); n++)
        runFrame(n);
      repeat (4) @(posedge macCoreTxClk);
      $display("Run complete: %0d frames, %0d bytes, %0d errors",
               frameTotal, byteTotal, errorCount);
      if (errorCount == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
      $finish;
    end
  end

  // 200 cycles per frame is far above the slowest busy pattern
  initial
  begin
    wait (traceLoaded);
    repeat (addrQ.size() * 200) @(posedge macCoreTxClk);
    $display("Timeout: run did not finish within %0d clock cycles", addrQ.size() * 200);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- test/formatCtsTrace.txt
# destAddr duration pwrMgt mode abort, then the ten expected frame bytes, all hex
# mode bit 1 selects PIFS, bit 0 SIFS, zero the slot tick; abort 1 cuts the frame by soft reset
0123456789ab 002c 0 1 0 c4 00 2c 00 ab 89 67 45 23 01
001122334455 7fff 1 2 0 c4 10 ff 7f 55 44 33 22 11 00
a0b1c2d3e4f5 0000 0 0 0 c4 00 00 00 f5 e4 d3 c2 b1 a0
ffffffffffff 1234 1 3 0 c4 10 34 12 ff ff ff ff ff ff
5a5aa5a55a5a 00f0 0 1 1 c4 00 f0 00 5a 5a a5 a5 5a 5a
0c0ffee00d15 0abc 1 1 0 c4 10 bc 0a 15 0d e0 fe 0f 0c
102030405060 8001 0 2 1 c4 00 01 80 60 50 40 30 20 10
02000000007e 0044 0 0 0 c4 00 44 00 7e 00 00 00 00 02
deadbeef0001 3a98 1 0 0 c4 10 98 3a 01 00 ef be ad de
8899aabbccdd 0101 0 3 0 c4 00 01 01 dd cc bb aa 99 88
13579bdf2468 ffff 1 1 1 c4 10 ff ff 68 24 df 9b 57 13
2468ace01357 00a0 0 2 0 c4 00 a0 00 57 13 e0 ac 68 24
7f7f7f7f7f7f 0200 1 0 1 c4 10 00 02 7f 7f 7f 7f 7f 7f
000000000001 0001 0 1 0 c4 00 01 00 01 00 00 00 00 00
800000000000 8000 1 2 0 c4 10 00 80 00 00 00 00 00 80
c0ffee123456 5e5e 0 0 0 c4 00 5e 5e 56 34 12 ee ff c0
6f5e4d3c2b1a 0cde 1 3 0 c4 10 de 0c 1a 2b 3c 4d 5e 6f
314159265358 9793 0 1 0 c4 00 93 97 58 53 26 59 41 31
271828182845 0904 1 0 0 c4 10 04 09 45 28 18 28 18 27
a1b2c3d4e5f6 0077 0 2 0 c4 00 77 00 f6 e5 d4 c3 b2 a1

//--- verilog.f
design/ctsFormatPkg.sv
design/ctsTxSequencer.sv
design/ctsFieldCounter.sv
design/ctsByteMux.sv
design/formatCts.sv
test/formatCtsTb.sv
